// ==== verilog/gb_core_pkg.sv ====
package gb_core_pkg;

    // T-cycles of one machine cycle
    typedef enum logic [1:0] {
        t1,
        t2,
        t3,
        t4
    } t_state_e;

    typedef enum logic [1:0] {
        bus_idle,
        bus_fetch,
        bus_read,
        bus_write
    } bus_op_e;

    // First eight follow opcode bits [5:3] of the ALU group
    typedef enum logic [3:0] {
        alu_add, alu_adc, alu_sub, alu_sbc,
        alu_and, alu_xor, alu_or, alu_cp,
        alu_inc, alu_pass
    } alu_op_e;

    typedef enum logic [3:0] {
        i_nop, i_ld_imm, i_ld_reg, i_ld_a_hl, i_ld_hl_a,
        i_alu_reg, i_alu_imm, i_inc, i_jp, i_jr, i_jr_cond,
        i_halt, i_illegal
    } instr_e;

    // Opcode register field order
    typedef enum logic [2:0] {
        reg_b, reg_c, reg_d, reg_e, reg_h, reg_l, reg_hl_mem, reg_a
    } reg_idx_e;

    localparam int FLAG_Z = 3;
    localparam int FLAG_N = 2;
    localparam int FLAG_H = 1;
    localparam int FLAG_C = 0;

    localparam logic [15:0] RESET_PC = 16'h0000;

endpackage

// ==== verilog/gb_fetch.sv ====
`timescale 1ns/1ns

module gb_fetch import gb_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  din,
    input  t_state_e    t_state,
    input  bus_op_e     bus_op,
    input  logic        imm_hi,
    output logic [7:0]  opcode,
    output logic [15:0] imm
);

    logic sample;

    // Edge entering t3 of a bus cycle
    assign sample = (t_state == t2);

    // Opcode latch, NOP after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            opcode <= 8'h00;
        end else if (sample && bus_op == bus_fetch) begin
            opcode <= din;
        end
    end

    // Immediate bytes, JP fills both halves
    always_ff @(posedge clk) begin
        if (sample && bus_op == bus_read) begin
            if (imm_hi) begin
                imm[15:8] <= din;
            end else begin
                imm[7:0] <= din;
            end
        end
    end

    ////////////////////
    // Memory must have answered by the time the byte is taken
    a_din_known: assert property (
        @(posedge clk) disable iff (rst)
        (sample && (bus_op == bus_fetch || bus_op == bus_read)) |-> !$isunknown(din)
    ) else $error("din unknown when sampled");

endmodule

// ==== verilog/gb_control.sv ====
`timescale 1ns/1ns

module gb_control import gb_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  opcode,
    input  logic [15:0] imm,
    input  t_state_e    t_state,
    input  logic        m_end,
    input  logic [3:0]  flags,
    input  logic [15:0] hl,
    input  logic [7:0]  acc,
    output bus_op_e     bus_op,
    output logic [15:0] bus_addr,
    output logic [7:0]  bus_data,
    output logic        imm_hi,
    output reg_idx_e    rf_rd_sel,
    output reg_idx_e    rf_wr_sel,
    output logic        rf_we,
    output logic        flags_we,
    output alu_op_e     alu_op,
    output logic        alu_b_imm,
    output logic        halted
);

    instr_e      instr;
    logic [1:0]  mc;            // Machine cycle within instruction
    logic [1:0]  mc_next;
    logic [1:0]  last_mc;
    logic        is_last;
    logic        step;
    logic        started;       // First machine cycle after reset is dead
    logic        halt_q;
    logic        halt_next;
    logic        jr_taken;
    logic        writes_reg;
    logic [15:0] pc;
    logic [15:0] pc_next;

    function automatic logic hl_cycle(instr_e i, logic [1:0] m);
        return (m != 2'd0) && (i == i_ld_a_hl || i == i_ld_hl_a);
    endfunction

    function automatic bus_op_e op_of(instr_e i, logic [1:0] m, logic idle);
        bus_op_e op;
        if (idle)
            op = bus_idle;
        else if (m == 2'd0)
            op = bus_fetch;
        else if (i == i_ld_hl_a)
            op = bus_write;
        else
            op = bus_read;
        return op;
    endfunction

    ////////////////////
    // Decode
    always_comb begin
        instr = i_illegal;
        case (opcode[7:6])
            2'b00: begin
                if (opcode == 8'h00)
                    instr = i_nop;
                else if (opcode == 8'h18)
                    instr = i_jr;
                else if (opcode == 8'h20 || opcode == 8'h28)
                    instr = i_jr_cond;
                else if (opcode[2:0] == 3'b110 && opcode[5:3] != 3'b110)
                    instr = i_ld_imm;
                else if (opcode[2:0] == 3'b100 && opcode[5:3] != 3'b110)
                    instr = i_inc;
            end
            2'b01: begin
                if (opcode == 8'h76)
                    instr = i_halt;
                else if (opcode == 8'h77)
                    instr = i_ld_hl_a;
                else if (opcode == 8'h7e)
                    instr = i_ld_a_hl;
                else if (opcode[5:3] != 3'b110 && opcode[2:0] != 3'b110)
                    instr = i_ld_reg;
            end
            2'b10: begin
                if (opcode[2:0] != 3'b110)
                    instr = i_alu_reg;
            end
            default: begin
                if (opcode == 8'hc3)
                    instr = i_jp;
                else if (opcode[2:0] == 3'b110)
                    instr = i_alu_imm;
            end
        endcase
    end

    always_comb begin
        case (instr)
            i_jp:                                    last_mc = 2'd2;
            i_ld_imm, i_alu_imm, i_ld_a_hl, i_ld_hl_a,
            i_jr, i_jr_cond:                         last_mc = 2'd1;
            default:                                 last_mc = 2'd0;
        endcase
    end

    assign is_last  = (mc == last_mc);
    assign step     = m_end && started && !halt_q;
    // opcode[3] picks Z over NZ
    assign jr_taken = (instr == i_jr) ||
                      (instr == i_jr_cond && opcode[3] == flags[FLAG_Z]);
    assign halt_next = halt_q || (step && is_last && instr == i_halt);
    assign mc_next   = step ? (is_last ? 2'd0 : mc + 2'd1) : mc;

    always_comb begin
        pc_next = pc;
        if (step) begin
            if (!hl_cycle(instr, mc))
                pc_next = pc + 16'd1;    // After fetch or immediate byte
            if (is_last && instr == i_jp)
                pc_next = imm;
            else if (is_last && jr_taken)
                pc_next = pc + 16'd1 + {{8{imm[7]}}, imm[7:0]};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            started <= 1'b0;
            halt_q  <= 1'b0;
            halted  <= 1'b0;
            mc      <= 2'd0;
            pc      <= RESET_PC;
        end else begin
            if (m_end)
                started <= 1'b1;
            halt_q <= halt_next;
            halted <= halt_q;            // done one clock after HALT completes
            mc     <= mc_next;
            pc     <= pc_next;
        end
    end

    ////////////////////
    // Bus request, next cycle presented during t4 for the driver to register
    always_comb begin
        if (m_end) begin
            bus_op   = op_of(instr, mc_next, halt_next);
            bus_addr = hl_cycle(instr, mc_next) ? hl : pc_next;
        end else begin
            bus_op   = op_of(instr, mc, !started || halt_q);
            bus_addr = hl_cycle(instr, mc) ? hl : pc;
        end
    end

    assign bus_data = acc;               // Only LD (HL),A stores
    assign imm_hi   = (mc == 2'd2);      // JP high address byte

    // Datapath steering
    always_comb begin
        case (instr)
            i_alu_reg, i_alu_imm: alu_op = alu_op_e'({1'b0, opcode[5:3]});
            i_inc:                alu_op = alu_inc;
            default:              alu_op = alu_pass;
        endcase
    end

    assign alu_b_imm  = (instr == i_ld_imm || instr == i_alu_imm || instr == i_ld_a_hl);
    assign rf_rd_sel  = (instr == i_inc) ? reg_idx_e'(opcode[5:3]) : reg_idx_e'(opcode[2:0]);
    assign rf_wr_sel  = (instr == i_ld_imm || instr == i_ld_reg || instr == i_inc) ?
                        reg_idx_e'(opcode[5:3]) : reg_a;
    assign writes_reg = (instr == i_ld_imm || instr == i_ld_reg || instr == i_ld_a_hl ||
                         instr == i_alu_reg || instr == i_alu_imm || instr == i_inc);
    assign rf_we      = step && is_last && writes_reg;
    assign flags_we   = step && is_last &&
                        (instr == i_alu_reg || instr == i_alu_imm || instr == i_inc);

    a_no_illegal: assert property (
        @(posedge clk) disable iff (rst)
        (started && mc == 2'd0 && t_state == t4) |-> (instr != i_illegal)
    ) else $error("illegal opcode %h at %h", opcode, pc);

endmodule

// ==== verilog/gb_regfile.sv ====
`timescale 1ns/1ns

module gb_regfile import gb_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_idx_e    rd_sel,
    output logic [7:0]  rd_data,
    input  reg_idx_e    wr_sel,
    input  logic [7:0]  wr_data,
    input  logic        we,
    input  logic [3:0]  flags_in,
    input  logic        flags_we,
    output logic [7:0]  acc,
    output logic [15:0] hl,
    output logic [3:0]  flags
);

    logic [7:0] regs [7];   // B C D E H L A

    // A moves into the (HL) hole
    function automatic logic [2:0] slot(reg_idx_e r);
        return (r == reg_a) ? 3'd6 : 3'(r);
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 7; i++)
                regs[i] <= 8'h00;
            flags <= 4'h0;
        end else begin
            if (we)
                regs[slot(wr_sel)] <= wr_data;
            if (flags_we)
                flags <= flags_in;
        end
    end

    assign rd_data = (rd_sel == reg_hl_mem) ? 8'h00 : regs[slot(rd_sel)];
    assign acc     = regs[6];
    assign hl      = {regs[4], regs[5]};

    a_no_hl_write: assert property (
        @(posedge clk) disable iff (rst) we |-> (wr_sel != reg_hl_mem)
    ) else $error("write to (HL) register slot");

endmodule

// ==== verilog/gb_alu.sv ====
`timescale 1ns/1ns

module gb_alu import gb_core_pkg::*; (
    input  logic [7:0] acc,
    input  logic [7:0] reg_data,
    input  logic [7:0] imm,
    input  logic       b_imm,
    input  alu_op_e    op,
    input  logic [3:0] flags_in,
    output logic [7:0] result,
    output logic [3:0] flags_out
);

    logic [7:0] op_b;
    logic       cin;
    logic [4:0] half;    // Bit 4 is carry or borrow out of bit 3
    logic [8:0] full;

    assign op_b = b_imm ? imm : reg_data;
    assign cin  = (op == alu_adc || op == alu_sbc) && flags_in[FLAG_C];

    always_comb begin
        half      = '0;
        full      = '0;
        result    = acc;
        flags_out = flags_in;
        case (op)
            alu_add, alu_adc: begin
                half   = {1'b0, acc[3:0]} + {1'b0, op_b[3:0]} + {4'd0, cin};
                full   = {1'b0, acc} + {1'b0, op_b} + {8'd0, cin};
                result = full[7:0];
                flags_out[FLAG_N] = 1'b0;
                flags_out[FLAG_H] = half[4];
                flags_out[FLAG_C] = full[8];
            end
            alu_sub, alu_sbc, alu_cp: begin
                half   = {1'b0, acc[3:0]} - {1'b0, op_b[3:0]} - {4'd0, cin};
                full   = {1'b0, acc} - {1'b0, op_b} - {8'd0, cin};
                result = (op == alu_cp) ? acc : full[7:0];
                flags_out[FLAG_N] = 1'b1;
                flags_out[FLAG_H] = half[4];
                flags_out[FLAG_C] = full[8];
            end
            alu_and: begin
                result = acc & op_b;
                flags_out[FLAG_N] = 1'b0;
                flags_out[FLAG_H] = 1'b1;
                flags_out[FLAG_C] = 1'b0;
            end
            alu_xor, alu_or: begin
                result = (op == alu_xor) ? (acc ^ op_b) : (acc | op_b);
                flags_out[FLAG_N] = 1'b0;
                flags_out[FLAG_H] = 1'b0;
                flags_out[FLAG_C] = 1'b0;
            end
            alu_inc: begin
                half   = {1'b0, reg_data[3:0]} + 5'd1;
                result = reg_data + 8'd1;
                flags_out[FLAG_N] = 1'b0;
                flags_out[FLAG_H] = half[4];        // C untouched
            end
            default: result = op_b;                 // Pass for loads
        endcase
        if (op != alu_pass)
            flags_out[FLAG_Z] = (op == alu_cp) ? (full[7:0] == 8'h00) : (result == 8'h00);
    end

endmodule

// ==== verilog/gb_bus_driver.sv ====
`timescale 1ns/1ns

module gb_bus_driver import gb_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  bus_op_e     bus_op,
    input  logic [15:0] bus_addr,
    input  logic [7:0]  bus_data,
    output t_state_e    t_state,
    output logic        m_end,
    output logic        phi,
    output logic [15:0] a,
    output logic [7:0]  dout,
    output logic        rd,
    output logic        wr
);

    assign m_end = (t_state == t4);

    ////////////////////
    // T-cycle counter and strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            t_state <= t1;
            phi     <= 1'b0;
            rd      <= 1'b0;
            wr      <= 1'b0;
            dout    <= 8'h00;
        end else begin
            t_state <= t_state_e'(t_state + 2'd1);    // Wraps t4 to t1
            case (t_state)
                t4: begin                              // Into t1
                    phi <= 1'b1;
                    rd  <= (bus_op == bus_fetch || bus_op == bus_read);
                end
                t2: begin                              // Into t3
                    phi <= 1'b0;
                    if (bus_op == bus_write) begin
                        wr   <= 1'b1;
                        dout <= bus_data;
                    end
                end
                t3: begin                              // Into t4
                    rd   <= 1'b0;
                    wr   <= 1'b0;
                    dout <= 8'h00;
                end
                default: ;
            endcase
        end
    end

    // Address held for the whole machine cycle
    always_ff @(posedge clk) begin
        if (t_state == t4)
            a <= bus_addr;
    end

    a_rd_wr_excl: assert property (
        @(posedge clk) disable iff (rst) !(rd && wr)
    ) else $error("rd and wr high together");

endmodule

// ==== verilog/gb_core.sv ====
`timescale 1ns/1ns

module gb_core import gb_core_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    output logic        phi,
    output logic [15:0] a,
    output logic [7:0]  dout,
    input  logic [7:0]  din,
    output logic        rd,
    output logic        wr,
    output logic        done
);

    t_state_e    t_state;
    logic        m_end;
    bus_op_e     bus_op;
    logic [15:0] bus_addr;
    logic [7:0]  bus_data;
    logic        imm_hi;
    logic [7:0]  opcode;
    logic [15:0] imm;

    reg_idx_e    rf_rd_sel;
    reg_idx_e    rf_wr_sel;
    logic        rf_we;
    logic        flags_we;
    logic [7:0]  rf_rd_data;
    logic [7:0]  acc;
    logic [15:0] hl;
    logic [3:0]  flags;

    alu_op_e     alu_op;
    logic        alu_b_imm;
    logic [7:0]  alu_result;
    logic [3:0]  alu_flags;

    ////////////////////
    // Input side
    gb_fetch fetch_inst (
        .clk     (clk),
        .rst     (rst),
        .din     (din),
        .t_state (t_state),
        .bus_op  (bus_op),
        .imm_hi  (imm_hi),
        .opcode  (opcode),
        .imm     (imm)
    );

    ////////////////////
    // Sequencing and datapath
    gb_control control_inst (
        .clk       (clk),
        .rst       (rst),
        .opcode    (opcode),
        .imm       (imm),
        .t_state   (t_state),
        .m_end     (m_end),
        .flags     (flags),
        .hl        (hl),
        .acc       (acc),
        .bus_op    (bus_op),
        .bus_addr  (bus_addr),
        .bus_data  (bus_data),
        .imm_hi    (imm_hi),
        .rf_rd_sel (rf_rd_sel),
        .rf_wr_sel (rf_wr_sel),
        .rf_we     (rf_we),
        .flags_we  (flags_we),
        .alu_op    (alu_op),
        .alu_b_imm (alu_b_imm),
        .halted    (done)
    );

    gb_regfile regfile_inst (
        .clk      (clk),
        .rst      (rst),
        .rd_sel   (rf_rd_sel),
        .rd_data  (rf_rd_data),
        .wr_sel   (rf_wr_sel),
        .wr_data  (alu_result),    // Every register write passes the ALU
        .we       (rf_we),
        .flags_in (alu_flags),
        .flags_we (flags_we),
        .acc      (acc),
        .hl       (hl),
        .flags    (flags)
    );

    gb_alu alu_inst (
        .acc       (acc),
        .reg_data  (rf_rd_data),
        .imm       (imm[7:0]),
        .b_imm     (alu_b_imm),
        .op        (alu_op),
        .flags_in  (flags),
        .result    (alu_result),
        .flags_out (alu_flags)
    );

    // Output side
    gb_bus_driver bus_driver_inst (
        .clk      (clk),
        .rst      (rst),
        .bus_op   (bus_op),
        .bus_addr (bus_addr),
        .bus_data (bus_data),
        .t_state  (t_state),
        .m_end    (m_end),
        .phi      (phi),
        .a        (a),
        .dout     (dout),
        .rd       (rd),
        .wr       (wr)
    );

endmodule

// ==== tb/tb_gb_core.sv ====
`timescale 1ns/1ns

module tb_gb_core;

    logic        clk;
    logic        rst;
    logic        phi;
    logic [15:0] a;
    logic [7:0]  dout;
    logic [7:0]  din;
    logic        rd;
    logic        wr;
    logic        done;

    logic [7:0]  mem [1024];
    logic [15:0] exp_addr [64];
    logic [7:0]  exp_data [64];
    int          n_exp;
    int          exp_count;
    int          n_lines;
    int          w_idx;
    int          cycles;
    int          limit;
    int          phase;         // T-cycle seen by the monitor, 0 is t1
    logic        exp_phi;
    logic        wr_q;
    logic        seen_rd;
    logic        seen_done;

    gb_core gb_core_inst (
        .clk  (clk),
        .rst  (rst),
        .phi  (phi),
        .a    (a),
        .dout (dout),
        .din  (din),
        .rd   (rd),
        .wr   (wr),
        .done (done)
    );

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(input string name, input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp)
            fail_run($sformatf("mismatch %s got %h expected %h", name, got, exp));
    endtask

    ////////////////////
    // Golden file reader
    task automatic read_golden();
        int          fd;
        int          code;
        logic [63:0] tag;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [8*200-1:0] rest;
        fd = $fopen("tb/gb_core_golden.txt", "r");
        if (fd == 0)
            fail_run("could not open tb/gb_core_golden.txt");
        while (!$feof(fd)) begin
            code = $fscanf(fd, "%s", tag);
            if (code != 1)
                break;
            if (tag == "#") begin
                code = $fgets(rest, fd);       // Column description
            end else if (tag == "P") begin
                code = $fscanf(fd, "%h %h", addr, data);
                mem[addr[9:0]] = data;
                n_lines++;
            end else if (tag == "W") begin
                code = $fscanf(fd, "%h %h", addr, data);
                exp_addr[n_exp] = addr;
                exp_data[n_exp] = data;
                n_exp++;
                n_lines++;
            end else if (tag == "C") begin
                code = $fscanf(fd, "%d", exp_count);
                n_lines++;
            end else begin
                fail_run("unknown tag in golden file");
            end
        end
        $fclose(fd);
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Memory answers during t1 ahead of the t3 sample
    always @(negedge clk) begin
        if (rd)
            din <= mem[a[9:0]];
    end

    ////////////////////
    // Bus monitor sees the values from before the edge
    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles > limit)
                fail_run("timeout, done never came");
            if (rd && wr)
                fail_run("rd and wr high together");
            if (seen_done && (rd || wr))
                fail_run("bus activity after done");
            if (rd && !seen_rd) begin
                check("a", a, 16'h0000);       // First fetch from reset PC
                seen_rd = 1'b1;
                phase   = 0;
            end
            if (seen_rd) begin
                exp_phi = (phase < 2);         // High in t1 and t2
                check("phi", {15'h0, phi}, {15'h0, exp_phi});
                if ((rd && phase == 3) || (wr && phase != 2))
                    fail_run("rd or wr high outside its T-cycle window");
                phase = (phase + 1) % 4;
            end
            if (wr && !wr_q) begin
                if (w_idx >= n_exp)
                    fail_run("more writes than the golden file expects");
                check("a", a, exp_addr[w_idx]);
                check("dout", {8'h00, dout}, {8'h00, exp_data[w_idx]});
                w_idx++;
            end
            wr_q = wr;
        end
    end

    initial begin
        rst       = 1'b1;
        din       = 8'h00;
        n_exp     = 0;
        exp_count = 0;
        n_lines   = 0;
        w_idx     = 0;
        cycles    = 0;
        phase     = 0;
        exp_phi   = 1'b0;
        wr_q      = 1'b0;
        seen_rd   = 1'b0;
        seen_done = 1'b0;
        for (int i = 0; i < 1024; i++)
            mem[i] = 8'h00;
        read_golden();
        limit = 16 * n_lines + 200;

        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("rd", {15'h0, rd}, 16'h0);
        check("wr", {15'h0, wr}, 16'h0);
        check("done", {15'h0, done}, 16'h0);

        // Timeout lives in the monitor
        while (!done)
            @(negedge clk);
        seen_done = 1'b1;
        check("write_count", w_idx[15:0], exp_count[15:0]);

        repeat (10) begin
            @(negedge clk);
            check("rd", {15'h0, rd}, 16'h0);
            check("wr", {15'h0, wr}, 16'h0);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

// ==== gb_core.f ====
verilog/gb_core_pkg.sv
verilog/gb_fetch.sv
verilog/gb_control.sv
verilog/gb_regfile.sv
verilog/gb_alu.sv
verilog/gb_bus_driver.sv
verilog/gb_core.sv
tb/tb_gb_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_gb_core -f gb_core.f \
    --Mdir obj_dir -o sim_gb_core
./obj_dir/sim_gb_core > sim.log 2>&1 || true
cat sim.log

if grep -q "Verification failed" sim.log; then
    echo "Simulation FAILED"
    exit 1
fi
echo "Simulation finished without failures"
exit 0

// ==== tb/gb_core_golden.txt ====
# P addr byte = memory preload, W addr data = expected bus write in order
# C count = expected number of writes
P 0000 26
P 0001 03
P 0002 2E
P 0003 00
P 0004 06
P 0005 12
P 0006 0E
P 0007 34
P 0008 16
P 0009 56
P 000A 1E
P 000B 78
P 000C 3E
P 000D 9A
P 000E 77
P 000F 78
P 0010 2C
P 0011 77
P 0012 79
P 0013 2C
P 0014 77
P 0015 7A
P 0016 2C
P 0017 77
P 0018 7B
P 0019 2C
P 001A 77
P 001B 7C
P 001C 2C
P 001D 77
P 001E 7D
P 001F 2C
P 0020 77
P 0021 43
P 0022 78
P 0023 2C
P 0024 77
P 0025 80
P 0026 2C
P 0027 77
P 0028 C6
P 0029 20
P 002A CE
P 002B 05
P 002C 2C
P 002D 77
P 002E 91
P 002F DE
P 0030 10
P 0031 2C
P 0032 77
P 0033 A2
P 0034 EE
P 0035 FF
P 0036 2C
P 0037 77
P 0038 B3
P 0039 D6
P 003A 0F
P 003B A9
P 003C 2C
P 003D 77
P 003E 88
P 003F 99
P 0040 2C
P 0041 77
P 0042 E6
P 0043 0F
P 0044 F6
P 0045 A0
P 0046 2C
P 0047 77
P 0048 3E
P 0049 0F
P 004A 3C
P 004B 2C
P 004C 77
P 004D FE
P 004E 10
P 004F 20
P 0050 02
P 0051 28
P 0052 03
P 0053 77
P 0056 BA
P 0057 28
P 0058 02
P 0059 20
P 005A 02
P 005B 77
P 005D C3
P 005E 70
P 005F 00
P 0060 77
P 0070 2C
P 0071 77
P 0072 18
P 0073 0A
P 0074 77
P 0076 26
P 0077 02
P 0078 2E
P 0079 40
P 007A 7E
P 007B 18
P 007C 05
P 007D 77
P 007E 18
P 007F F6
P 0082 26
P 0083 03
P 0084 2E
P 0085 11
P 0086 77
P 0087 26
P 0088 02
P 0089 2E
P 008A 41
P 008B 7E
P 008C 26
P 008D 03
P 008E 2E
P 008F 12
P 0090 77
P 0091 76
P 0240 5A
P 0241 C3
W 0300 9A
W 0301 12
W 0302 34
W 0303 56
W 0304 78
W 0305 03
W 0306 05
W 0307 78
W 0308 F0
W 0309 16
W 030A D1
W 030B AF
W 030C C4
W 030D 07
W 030E A7
W 030F 10
W 0310 10
W 0311 5A
W 0312 C3
C 19
